// File: hdl/texelPkg.sv
// texel decoder package with block field layout, channel sizes and payload structs
package texelPkg;

	// channel widths
	localparam int chanRawWidth = 8;
	localparam int chanWidth = 12;
	localparam int texelChanWidth = 16;

	localparam int pixelCount = 16;
	localparam int indexWidth = 2;

	// base bits inside the block
	localparam int endpointAOffset = 0;
	localparam int endpointBOffset = 32;
	localparam int permOffset = 62;

	// alpha indices sit in the upper half of the selector word
	localparam int alphaIndexOffset = 32;

	typedef enum logic [1:0] {
		permNone = 2'd0,
		permSwapRA = 2'd1,
		permSwapGA = 2'd2,
		permSwapBA = 2'd3
	} channelPerm_e;

	typedef struct packed {
		logic [chanWidth-1:0] a;
		logic [chanWidth-1:0] r;
		logic [chanWidth-1:0] g;
		logic [chanWidth-1:0] b;
	} rgba12_t;

	typedef struct packed {
		logic [63:0] block;
		logic [2*pixelCount*indexWidth-1:0] selectors;
		logic [$clog2(pixelCount)-1:0] pixelIndex;
	} texelRequest_t;

	// both endpoints, both interpolants and the permutation
	typedef struct packed {
		rgba12_t colorA;
		rgba12_t colorB;
		rgba12_t interpA;
		rgba12_t interpB;
		channelPerm_e perm;
	} endpointSet_t;

	typedef struct packed {
		logic [indexWidth-1:0] colorIndex;
		logic [indexWidth-1:0] alphaIndex;
	} selectorPair_t;

	typedef struct packed {
		logic [texelChanWidth-1:0] a;
		logic [texelChanWidth-1:0] r;
		logic [texelChanWidth-1:0] g;
		logic [texelChanWidth-1:0] b;
	} texel_t;

endpackage

// File: hdl/pipeStage.sv
// one-entry valid/ready register stage for any payload type
module pipeStage #(
	parameter type payload_t = logic
) (
	input logic clock,
	input logic reset,
	input logic inValid,
	input payload_t inData,
	input logic outReady,
	output logic inReady,
	output logic outValid,
	output payload_t outData
);

	logic full;
	payload_t data;

	// room when empty or when the entry leaves this cycle
	assign inReady = !full || outReady;
	assign outValid = full;
	assign outData = data;

	always_ff @(posedge clock) begin
		if (reset) begin
			full <= 1'b0;
		end else if (inReady) begin
			full <= inValid;
		end
	end

	always_ff @(posedge clock) begin
		if (inReady && inValid) begin
			data <= inData;
		end
	end

endmodule

// File: hdl/endpointExpand.sv
// endpoint expander that unpacks both block endpoints to 12 bits and blends the two interpolants
module endpointExpand
	import texelPkg::*;
(
	input logic [63:0] block,
	output endpointSet_t endpoints
);

	rgba12_t colorA;
	rgba12_t colorB;
	rgba12_t interpA;
	rgba12_t interpB;

	// replicate the top bits into the new low bits
	function automatic logic [chanWidth-1:0] widen(input logic [chanRawWidth-1:0] raw);
		return {raw, raw[chanRawWidth-1 -: chanWidth-chanRawWidth]};
	endfunction

	// alpha 8 bits, red 7, green 8, blue 7
	function automatic rgba12_t unpackEndpoint(input logic [29:0] field);
		rgba12_t color;
		color.a = widen(field[29:22]);
		color.r = widen({field[21:15], 1'b0});
		color.g = widen(field[14:7]);
		color.b = widen({field[6:0], 1'b0});
		return color;
	endfunction

	// (5 * heavy + 3 * light) / 8 truncated
	function automatic logic [chanWidth-1:0] blend(
		input logic [chanWidth-1:0] heavy,
		input logic [chanWidth-1:0] light
	);
		logic [chanWidth+2:0] sum;
		sum = ({3'b000, heavy} << 2) + {3'b000, heavy}
			+ ({3'b000, light} << 1) + {3'b000, light};
		return sum[chanWidth+2:3];
	endfunction

	assign colorA = unpackEndpoint(block[endpointAOffset +: 30]);
	assign colorB = unpackEndpoint(block[endpointBOffset +: 30]);

	always_comb begin
		interpA.a = blend(colorA.a, colorB.a);
		interpA.r = blend(colorA.r, colorB.r);
		interpA.g = blend(colorA.g, colorB.g);
		interpA.b = blend(colorA.b, colorB.b);

		interpB.a = blend(colorB.a, colorA.a);
		interpB.r = blend(colorB.r, colorA.r);
		interpB.g = blend(colorB.g, colorA.g);
		interpB.b = blend(colorB.b, colorA.b);
	end

	always_comb begin
		endpoints.colorA = colorA;
		endpoints.colorB = colorB;
		endpoints.interpA = interpA;
		endpoints.interpB = interpB;
		// bit 30 is ignored since endpoints are always unsigned normalized
		endpoints.perm = channelPerm_e'(block[permOffset +: $bits(channelPerm_e)]);
	end

endmodule

// File: hdl/indexSelect.sv
// index selector that pulls one pixel's color and alpha indices out of the selector word
module indexSelect
	import texelPkg::*;
(
	input logic [2*pixelCount*indexWidth-1:0] selectors,
	input logic [$clog2(pixelCount)-1:0] pixelIndex,
	output selectorPair_t indices
);

	localparam int halfWidth = pixelCount * indexWidth;
	localparam int offsetWidth = $clog2(halfWidth);

	logic [halfWidth-1:0] colorHalf;
	logic [halfWidth-1:0] alphaHalf;
	logic [offsetWidth-1:0] bitOffset;

	// color indices low, alpha indices high
	assign colorHalf = selectors[alphaIndexOffset-1:0];
	assign alphaHalf = selectors[alphaIndexOffset +: halfWidth];

	// pixel i starts at bit 2i in each half
	assign bitOffset = offsetWidth'(pixelIndex * indexWidth);

	always_comb begin
		indices.colorIndex = colorHalf[bitOffset +: indexWidth];
		indices.alphaIndex = alphaHalf[bitOffset +: indexWidth];
	end

endmodule

// File: hdl/texelCombine.sv
// texel combiner that picks each channel by index, applies the alpha swap and widens to 16 bits
module texelCombine
	import texelPkg::*;
(
	input endpointSet_t endpoints,
	input selectorPair_t indices,
	output texel_t texel
);

	rgba12_t picked;
	rgba12_t swapped;

	// 0 endpoint B, 1 and 2 the interpolants, 3 endpoint A
	function automatic logic [chanWidth-1:0] pickChannel(
		input logic [indexWidth-1:0] sel,
		input logic [chanWidth-1:0] colorB,
		input logic [chanWidth-1:0] interpB,
		input logic [chanWidth-1:0] interpA,
		input logic [chanWidth-1:0] colorA
	);
		logic [chanWidth-1:0] chan;
		case (sel)
			2'd0: chan = colorB;
			2'd1: chan = interpB;
			2'd2: chan = interpA;
			default: chan = colorA;
		endcase
		return chan;
	endfunction

	function automatic logic [texelChanWidth-1:0] widen(input logic [chanWidth-1:0] chan);
		return {chan, chan[chanWidth-1 -: texelChanWidth-chanWidth]};
	endfunction

	always_comb begin
		picked.a = pickChannel(indices.alphaIndex, endpoints.colorB.a,
			endpoints.interpB.a, endpoints.interpA.a, endpoints.colorA.a);
		picked.r = pickChannel(indices.colorIndex, endpoints.colorB.r,
			endpoints.interpB.r, endpoints.interpA.r, endpoints.colorA.r);
		picked.g = pickChannel(indices.colorIndex, endpoints.colorB.g,
			endpoints.interpB.g, endpoints.interpA.g, endpoints.colorA.g);
		picked.b = pickChannel(indices.colorIndex, endpoints.colorB.b,
			endpoints.interpB.b, endpoints.interpA.b, endpoints.colorA.b);
	end

	// alpha trades places with one color channel
	always_comb begin
		swapped = picked;
		case (endpoints.perm)
			permSwapRA: begin
				swapped.a = picked.r;
				swapped.r = picked.a;
			end
			permSwapGA: begin
				swapped.a = picked.g;
				swapped.g = picked.a;
			end
			permSwapBA: begin
				swapped.a = picked.b;
				swapped.b = picked.a;
			end
			default: swapped = picked;
		endcase
	end

	always_comb begin
		texel.a = widen(swapped.a);
		texel.r = widen(swapped.r);
		texel.g = widen(swapped.g);
		texel.b = widen(swapped.b);
	end

endmodule

// File: hdl/utxTexelDecoder.sv
// texel decoder top level wiring the input stage, endpoint and index decode, combiner and output stage
module utxTexelDecoder
	import texelPkg::*;
(
	input logic clock,
	input logic reset,
	input logic inValid,
	input texelRequest_t inRequest,
	input logic outReady,
	output logic inReady,
	output logic outValid,
	output texel_t outTexel
);

	texelRequest_t request;
	logic requestValid;
	logic requestReady;
	endpointSet_t endpoints;
	selectorPair_t indices;
	texel_t texel;

	pipeStage #(.payload_t(texelRequest_t)) inStage (
		.clock(clock),
		.reset(reset),
		.inValid(inValid),
		.inData(inRequest),
		.outReady(requestReady),
		.inReady(inReady),
		.outValid(requestValid),
		.outData(request)
	);

	// both decode halves work side by side on the held request
	endpointExpand expand (
		.block(request.block),
		.endpoints(endpoints)
	);

	indexSelect select (
		.selectors(request.selectors),
		.pixelIndex(request.pixelIndex),
		.indices(indices)
	);

	texelCombine combine (
		.endpoints(endpoints),
		.indices(indices),
		.texel(texel)
	);

	pipeStage #(.payload_t(texel_t)) outStage (
		.clock(clock),
		.reset(reset),
		.inValid(requestValid),
		.inData(texel),
		.outReady(outReady),
		.inReady(requestReady),
		.outValid(outValid),
		.outData(outTexel)
	);

endmodule

// File: test/texelChecker.sv
// output checker that compares every texel leaving the decoder with the next expected one
module texelChecker
	import texelPkg::*;
(
	input logic clock,
	input logic reset,
	input logic outValid,
	input logic outReady,
	input texel_t outTexel
);

	texel_t expected[$];
	texel_t want;
	int resultCount = 0;
	int mismatchCount = 0;
	int otherErrors = 0;

	// queued in request order, popped in result order
	function automatic void addExpected(input texel_t value);
		expected.push_back(value);
	endfunction

	always @(posedge clock) begin
		if (!reset && outValid && outReady) begin
			if (expected.size() == 0) begin
				otherErrors++;
				$display("texel %h left the decoder at time %0t with no request outstanding",
					outTexel, $time);
			end else begin
				want = expected.pop_front();
				if (outTexel === want) begin
					$display("test %0d pass, texel %h", resultCount, outTexel);
				end else begin
					mismatchCount++;
					$display("MISMATCH at time %0t: test %0d expected %h got %h",
						$time, resultCount, want, outTexel);
				end
				resultCount++;
			end
		end
	end

endmodule

// File: test/utxTexelDecoder_asserts.sv
// handshake, latency and reset assertions on the texel decoder ports
module utxTexelDecoder_asserts
	import texelPkg::*;
(
	input logic clock,
	input logic reset,
	input logic inValid,
	input logic inReady,
	input logic outValid,
	input logic outReady,
	input texel_t outTexel
);

	int failCount = 0;

	// both stages come out of reset empty
	resetEmpty: assert property (@(posedge clock) reset |=> !outValid)
		else begin
			failCount++;
			$error("outValid high one cycle after reset");
		end

	outHeld: assert property (@(posedge clock) disable iff (reset)
		outValid && !outReady |=> outValid && $stable(outTexel))
		else begin
			failCount++;
			$error("stalled texel dropped or changed");
		end

	// an empty output stage always makes room upstream
	inOpen: assert property (@(posedge clock) disable iff (reset) !outValid |-> inReady)
		else begin
			failCount++;
			$error("inReady low while the output stage is empty");
		end

	twoEdges: assert property (@(posedge clock) disable iff (reset)
		(inValid && inReady) ##1 outReady |=> outValid)
		else begin
			failCount++;
			$error("texel not valid two edges after the request was taken");
		end

endmodule

bind utxTexelDecoder utxTexelDecoder_asserts asserts (
	.clock(clock),
	.reset(reset),
	.inValid(inValid),
	.inReady(inReady),
	.outValid(outValid),
	.outReady(outReady),
	.outTexel(outTexel)
);

// File: test/utxTexelDecoder_tb.sv
// texel decoder testbench that replays the trace with random input gaps and output back-pressure
module utxTexelDecoder_tb
	import texelPkg::*;
();

	localparam int cyclesPerTest = 20;
	localparam int cycleMargin = 100;

	logic clock = 1'b0;
	logic reset;
	logic inValid;
	texelRequest_t inRequest;
	logic outReady;
	logic inReady;
	logic outValid;
	texel_t outTexel;

	texelRequest_t requests[$];
	texel_t expectedTexels[$];
	int testCount = 0;
	int cycleLimit = 0;
	int cycleCount = 0;
	logic holdReady;
	logic readyNext;

	utxTexelDecoder dut (
		.clock(clock),
		.reset(reset),
		.inValid(inValid),
		.inRequest(inRequest),
		.outReady(outReady),
		.inReady(inReady),
		.outValid(outValid),
		.outTexel(outTexel)
	);

	texelChecker outCheck (
		.clock(clock),
		.reset(reset),
		.outValid(outValid),
		.outReady(outReady),
		.outTexel(outTexel)
	);

	always #2 clock = ~clock;

	// back-pressure is chosen at the edge and driven just after it
	always @(posedge clock) begin
		readyNext = holdReady || ($urandom_range(0, 3) != 0);
		#1;
		outReady = readyNext;
	end

	always @(posedge clock) begin
		cycleCount++;
		if (cycleLimit > 0 && cycleCount >= cycleLimit) begin
			#1;
			$display("timeout after %0d cycles, %0d of %0d results never arrived",
				cycleCount, testCount - outCheck.resultCount, testCount);
			$display("Errors found");
			$finish;
		end
	end

	function automatic bit loadTrace();
		int fd;
		string line;
		logic [63:0] block;
		logic [63:0] selectors;
		logic [3:0] pixel;
		logic [63:0] texel;
		texelRequest_t request;
		fd = $fopen("test/texelTrace.txt", "r");
		if (fd == 0) begin
			return 1'b0;
		end
		while (!$feof(fd)) begin
			line = "";
			void'($fgets(line, fd));
			// lines starting with # only name the columns
			if (line.len() > 0 && line.getc(0) != "#" &&
					$sscanf(line, "%h %h %h %h", block, selectors, pixel, texel) == 4) begin
				request.block = block;
				request.selectors = selectors;
				request.pixelIndex = pixel;
				requests.push_back(request);
				expectedTexels.push_back(texel);
			end
		end
		$fclose(fd);
		return 1'b1;
	endfunction

	// starts just after an edge and returns just after the edge that took the request
	task automatic sendRequest(input int idx);
		int gap;
		gap = $urandom_range(0, 2);
		if (gap > 0) begin
			inValid = 1'b0;
			repeat (gap) begin
				@(posedge clock);
				#1;
			end
		end
		inValid = 1'b1;
		inRequest = requests[idx];
		outCheck.addExpected(expectedTexels[idx]);
		@(posedge clock);
		while (!inReady) begin
			@(posedge clock);
		end
		#1;
	endtask

	task automatic runTests();
		int errorCount;
		repeat (3) @(posedge clock);
		#1;
		reset = 1'b0;
		foreach (requests[i]) begin
			// first half with outReady held high, the rest under random back-pressure
			holdReady = (i < testCount / 2);
			sendRequest(i);
		end
		inValid = 1'b0;
		while (outCheck.resultCount < testCount) begin
			@(posedge clock);
			#1;
		end
		repeat (2) @(posedge clock);
		#1;
		errorCount = outCheck.mismatchCount + outCheck.otherErrors + dut.asserts.failCount;
		$display("%0d tests, %0d results, %0d mismatches, %0d other errors, %0d assertion failures",
			testCount, outCheck.resultCount, outCheck.mismatchCount, outCheck.otherErrors,
			dut.asserts.failCount);
		if (errorCount == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	endtask

	initial begin
		void'($urandom(32'h2a5763aa));
		reset = 1'b1;
		inValid = 1'b0;
		inRequest = '0;
		outReady = 1'b0;
		holdReady = 1'b1;
		if (!loadTrace() || requests.size() == 0) begin
			$display("could not read any test from test/texelTrace.txt");
			$display("Errors found");
			$finish;
		end else begin
			testCount = requests.size();
			cycleLimit = testCount * cyclesPerTest + cycleMargin;
			runTests();
		end
	end

endmodule

// File: test/texelTrace.txt
# columns: block, selector word, pixel index, expected texel (a r g b), all hex
# corner and interpolant selectors, split indices, pixel walk, then permutations
0000007f3fffc000 ffffffffffffffff 0 fffffeff80880000
0000007f3fffc000 0000000000000000 5 000000000000feff
0000007f3fffc000 aaaaaaaaaaaaaaaa a 9ff99f5950555f95
0000007f3fffc000 5555555555555555 f 5ff55f9530339f59
2404c84723c447c8 ffffffffffffffff 3 8f8810118f889099
2404c84723c447c8 0000000000000000 c 9099121190998e88
2404c84723c447c8 aaaaaaaaaaaaaaaa 7 8fe810d18fe88fc8
2404c84723c447c8 5555555555555555 1 9029115190298f48
0000007f3fffc000 ffffffff00000000 9 ffff00000000feff
0000007f3fffc000 55555555aaaaaaaa 2 5ff59f5950555f95
0000007f3fffc000 ffaa5500e4e4e4e4 0 000000000000feff
0000007f3fffc000 ffaa5500e4e4e4e4 1 00005f9530339f59
0000007f3fffc000 ffaa5500e4e4e4e4 2 00009f5950555f95
0000007f3fffc000 ffaa5500e4e4e4e4 3 0000feff80880000
0000007f3fffc000 ffaa5500e4e4e4e4 4 5ff500000000feff
0000007f3fffc000 ffaa5500e4e4e4e4 5 5ff55f9530339f59
0000007f3fffc000 ffaa5500e4e4e4e4 6 5ff59f5950555f95
0000007f3fffc000 ffaa5500e4e4e4e4 7 5ff5feff80880000
0000007f3fffc000 ffaa5500e4e4e4e4 8 9ff900000000feff
0000007f3fffc000 ffaa5500e4e4e4e4 9 9ff95f9530339f59
0000007f3fffc000 ffaa5500e4e4e4e4 a 9ff99f5950555f95
0000007f3fffc000 ffaa5500e4e4e4e4 b 9ff9feff80880000
0000007f3fffc000 ffaa5500e4e4e4e4 c ffff00000000feff
0000007f3fffc000 ffaa5500e4e4e4e4 d ffff5f9530339f59
0000007f3fffc000 ffaa5500e4e4e4e4 e ffff9f5950555f95
0000007f3fffc000 ffaa5500e4e4e4e4 f fffffeff80880000
0000007f7fffc000 ffffffffffffffff 6 fffffeff80880000
4000007f3fffc000 ffffffffffffffff 8 feffffff80880000
8000007f3fffc000 ffffffffffffffff b 8088feffffff0000
c000007f3fffc000 ffffffffffffffff d 0000feff8088ffff

// File: utxTexelDecoder.f
hdl/texelPkg.sv
hdl/pipeStage.sv
hdl/endpointExpand.sv
hdl/indexSelect.sv
hdl/texelCombine.sv
hdl/utxTexelDecoder.sv
test/texelChecker.sv
test/utxTexelDecoder_asserts.sv
test/utxTexelDecoder_tb.sv

// File: Bender.yml
package:
  name: utxTexelDecoder

sources:
  - hdl/texelPkg.sv
  - hdl/pipeStage.sv
  - hdl/endpointExpand.sv
  - hdl/indexSelect.sv
  - hdl/texelCombine.sv
  - hdl/utxTexelDecoder.sv
  - target: test
    files:
      - test/texelChecker.sv
      - test/utxTexelDecoder_asserts.sv
      - test/utxTexelDecoder_tb.sv
